// ==== build.f ====
logic/core_cfg_pkg.sv
logic/wb_pkg.sv
logic/wb_fifo.sv
logic/wb_arbiter.sv
logic/wb_unit.sv
logic/reg_file.sv
logic/wb_top.sv
sim/wb_tb.sv

// ==== logic/core_cfg_pkg.sv ====
// core configuration: widths and base types shared by the whole core
package core_cfg_pkg;

    // datapath and tag widths
    localparam int REG_DATA_W  = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int CSR_ADDR_W  = 12;
    localparam int COMMIT_ID_W = 3;

    // integer register count, x0 included
    localparam int NUM_REGS = 1 << REG_ADDR_W;

    typedef logic [REG_DATA_W-1:0]  reg_data_t;
    typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [CSR_ADDR_W-1:0]  csr_addr_t;

    // tag handed out by the issue stage, returned on commit
    typedef logic [COMMIT_ID_W-1:0] commit_id_t;

endpackage

// ==== logic/reg_file.sv ====
// integer register file, 32 entries, x0 hardwired to zero, one read port
`timescale 1ns/1ns

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  wb_pkg::reg_wr_t        wr_i,
    input  core_cfg_pkg::reg_addr_t rs_addr_i,
    output core_cfg_pkg::reg_data_t rs_data_o
);
    import core_cfg_pkg::*;

    reg_data_t regs [NUM_REGS];
    logic      wr_en;

    // x0 stays at its reset value of zero
    assign wr_en = wr_i.we && (wr_i.addr != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // combinational read, new value visible after the write edge
    assign rs_data_o = regs[rs_addr_i];

endmodule

// ==== logic/wb_arbiter.sv ====
// fixed-priority writeback arbiter: lsu, then parked writes, then direct writes
`timescale 1ns/1ns

module wb_arbiter (
    input  wb_pkg::reg_wr_t lsu_wr_i,
    input  wb_pkg::reg_wr_t mul_wr_i,
    input  wb_pkg::reg_wr_t div_wr_i,
    input  wb_pkg::reg_wr_t csr_wr_i,
    input  wb_pkg::reg_wr_t alu_wr_i,
    input  wb_pkg::reg_wr_t mul_head_i,
    input  wb_pkg::reg_wr_t div_head_i,
    input  wb_pkg::reg_wr_t csr_head_i,
    input  wb_pkg::reg_wr_t alu_head_i,
    input  logic            mul_empty_i,
    input  logic            div_empty_i,
    input  logic            csr_empty_i,
    input  logic            alu_empty_i,
    input  logic            mul_full_i,
    input  logic            div_full_i,
    input  logic            csr_full_i,
    input  logic            alu_full_i,
    output logic [3:0]      push_o,
    output logic [3:0]      pop_o,
    output logic [3:0]      ready_o,
    output wb_pkg::wb_src_e grant_o,
    output wb_pkg::reg_wr_t sel_o
);
    import wb_pkg::*;

    // bit order in every vector: 0 mul, 1 div, 2 csr, 3 alu
    logic [3:0] req;
    logic [3:0] empty;
    logic [3:0] accept;
    logic [3:0] direct;
    logic       lsu_act;
    logic       any_parked;

    assign req     = {alu_wr_i.we, csr_wr_i.we, div_wr_i.we, mul_wr_i.we};
    assign empty   = {alu_empty_i, csr_empty_i, div_empty_i, mul_empty_i};
    assign ready_o = ~{alu_full_i, csr_full_i, div_full_i, mul_full_i};

    assign lsu_act    = lsu_wr_i.we;
    assign accept     = req & ready_o;
    assign any_parked = ~&empty;

    // drain parked entries while the lsu leaves the port free
    always_comb begin
        pop_o = '0;
        if (!lsu_act) begin
            for (int i = 0; i < 4; i++) begin
                if (!empty[i] && pop_o == '0) begin
                    pop_o[i] = 1'b1;
                end
            end
        end
    end

    // a direct write may only pass when nothing at all is waiting
    always_comb begin
        direct = '0;
        if (!lsu_act && !any_parked) begin
            for (int i = 0; i < 4; i++) begin
                if (accept[i] && direct == '0) begin
                    direct[i] = 1'b1;
                end
            end
        end
    end

    // every accepted write that lost the port gets parked
    assign push_o = accept & ~direct;

    always_comb begin
        sel_o   = '0;
        grant_o = NONE;
        if (lsu_act) begin
            sel_o   = lsu_wr_i;
            grant_o = LSU;
        end else if (pop_o[0] || direct[0]) begin
            sel_o   = pop_o[0] ? mul_head_i : mul_wr_i;
            grant_o = MUL;
        end else if (pop_o[1] || direct[1]) begin
            sel_o   = pop_o[1] ? div_head_i : div_wr_i;
            grant_o = DIV;
        end else if (pop_o[2] || direct[2]) begin
            sel_o   = pop_o[2] ? csr_head_i : csr_wr_i;
            grant_o = CSR;
        end else if (pop_o[3] || direct[3]) begin
            sel_o   = pop_o[3] ? alu_head_i : alu_wr_i;
            grant_o = ALU;
        end
        sel_o.we = (grant_o != NONE);
    end

endmodule

// ==== logic/wb_fifo.sv ====
// parking FIFO holding the register writes of one producer
`timescale 1ns/1ns

module wb_fifo #(
    parameter int FIFO_DEPTH = 2
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            push_i,
    input  wb_pkg::reg_wr_t entry_i,
    input  logic            pop_i,
    output wb_pkg::reg_wr_t head_o,
    output logic            empty_o,
    output logic            full_o
);
    import wb_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    reg_wr_t          mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // wrap at the last slot, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= entry_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop_i) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // simultaneous push and pop leaves the count alone
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    assign head_o  = mem[rd_ptr];
    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(FIFO_DEPTH));

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push_i |-> !full_o);
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop_i |-> !empty_o);

endmodule

// ==== logic/wb_pkg.sv ====
// writeback types: producer write requests, commit report and source codes
package wb_pkg;

    import core_cfg_pkg::*;

    // one register write from an execution unit
    typedef struct packed {
        logic       we;
        reg_addr_t  addr;
        reg_data_t  data;
        commit_id_t id;
    } reg_wr_t;

    // write to the external CSR file
    typedef struct packed {
        logic      we;
        csr_addr_t addr;
        reg_data_t data;
    } csr_wr_t;

    // completion report towards hazard logic
    typedef struct packed {
        logic       valid;
        commit_id_t id;
    } commit_t;

    // arbiter grant, NONE when the port stays idle
    typedef enum logic [2:0] {
        NONE = 3'd0,
        LSU  = 3'd1,
        MUL  = 3'd2,
        DIV  = 3'd3,
        CSR  = 3'd4,
        ALU  = 3'd5
    } wb_src_e;

endpackage

// ==== logic/wb_top.sv ====
// writeback top level: writeback unit feeding the integer register file
`timescale 1ns/1ns

module wb_top #(
    parameter int FIFO_DEPTH = 2
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  wb_pkg::reg_wr_t         lsu_wr_i,
    input  wb_pkg::reg_wr_t         mul_wr_i,
    input  wb_pkg::reg_wr_t         div_wr_i,
    input  wb_pkg::reg_wr_t         csr_reg_wr_i,
    input  wb_pkg::reg_wr_t         alu_wr_i,
    input  wb_pkg::csr_wr_t         csr_wr_i,
    input  core_cfg_pkg::reg_addr_t rs_addr_i,
    output logic                    mul_ready_o,
    output logic                    div_ready_o,
    output logic                    csr_ready_o,
    output logic                    alu_ready_o,
    output wb_pkg::commit_t         commit_o,
    output wb_pkg::csr_wr_t         csr_wr_o,
    output core_cfg_pkg::reg_data_t rs_data_o
);
    import wb_pkg::*;

    // registered write from the unit into the register file
    reg_wr_t rf_wr;

    wb_unit #(.FIFO_DEPTH(FIFO_DEPTH)) u_wb_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .lsu_wr_i     (lsu_wr_i),
        .mul_wr_i     (mul_wr_i),
        .div_wr_i     (div_wr_i),
        .csr_reg_wr_i (csr_reg_wr_i),
        .alu_wr_i     (alu_wr_i),
        .csr_wr_i     (csr_wr_i),
        .mul_ready_o  (mul_ready_o),
        .div_ready_o  (div_ready_o),
        .csr_ready_o  (csr_ready_o),
        .alu_ready_o  (alu_ready_o),
        .rf_wr_o      (rf_wr),
        .commit_o     (commit_o),
        .csr_wr_o     (csr_wr_o)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_i      (rf_wr),
        .rs_addr_i (rs_addr_i),
        .rs_data_o (rs_data_o)
    );

endmodule

// ==== logic/wb_unit.sv ====
// writeback unit: parking FIFOs, arbitration, output register and CSR delay
`timescale 1ns/1ns

module wb_unit #(
    parameter int FIFO_DEPTH = 2
) (
    input  logic            clk,
    input  logic            rst_n,
    input  wb_pkg::reg_wr_t lsu_wr_i,
    input  wb_pkg::reg_wr_t mul_wr_i,
    input  wb_pkg::reg_wr_t div_wr_i,
    input  wb_pkg::reg_wr_t csr_reg_wr_i,
    input  wb_pkg::reg_wr_t alu_wr_i,
    input  wb_pkg::csr_wr_t csr_wr_i,
    output logic            mul_ready_o,
    output logic            div_ready_o,
    output logic            csr_ready_o,
    output logic            alu_ready_o,
    output wb_pkg::reg_wr_t rf_wr_o,
    output wb_pkg::commit_t commit_o,
    output wb_pkg::csr_wr_t csr_wr_o
);
    import core_cfg_pkg::*;
    import wb_pkg::*;

    // index 0 mul, 1 div, 2 csr, 3 alu, as in the arbiter
    reg_wr_t    src_wr [4];
    reg_wr_t    fifo_head [4];
    logic [3:0] fifo_push;
    logic [3:0] fifo_pop;
    logic [3:0] fifo_empty;
    logic [3:0] fifo_full;
    logic [3:0] ready;
    wb_src_e    grant;
    reg_wr_t    sel_wr;

    // output stage, enables reset, payload free running
    logic       rf_we_q;
    reg_addr_t  rf_addr_q;
    reg_data_t  rf_data_q;
    commit_id_t rf_id_q;
    logic       csr_we_q;
    csr_addr_t  csr_addr_q;
    reg_data_t  csr_data_q;

    assign src_wr[0] = mul_wr_i;
    assign src_wr[1] = div_wr_i;
    assign src_wr[2] = csr_reg_wr_i;
    assign src_wr[3] = alu_wr_i;

    for (genvar i = 0; i < 4; i++) begin : gen_fifo
        wb_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
            .clk     (clk),
            .rst_n   (rst_n),
            .push_i  (fifo_push[i]),
            .entry_i (src_wr[i]),
            .pop_i   (fifo_pop[i]),
            .head_o  (fifo_head[i]),
            .empty_o (fifo_empty[i]),
            .full_o  (fifo_full[i])
        );
    end

    wb_arbiter u_arbiter (
        .lsu_wr_i    (lsu_wr_i),
        .mul_wr_i    (mul_wr_i),
        .div_wr_i    (div_wr_i),
        .csr_wr_i    (csr_reg_wr_i),
        .alu_wr_i    (alu_wr_i),
        .mul_head_i  (fifo_head[0]),
        .div_head_i  (fifo_head[1]),
        .csr_head_i  (fifo_head[2]),
        .alu_head_i  (fifo_head[3]),
        .mul_empty_i (fifo_empty[0]),
        .div_empty_i (fifo_empty[1]),
        .csr_empty_i (fifo_empty[2]),
        .alu_empty_i (fifo_empty[3]),
        .mul_full_i  (fifo_full[0]),
        .div_full_i  (fifo_full[1]),
        .csr_full_i  (fifo_full[2]),
        .alu_full_i  (fifo_full[3]),
        .push_o      (fifo_push),
        .pop_o       (fifo_pop),
        .ready_o     (ready),
        .grant_o     (grant),
        .sel_o       (sel_wr)
    );

    assign mul_ready_o = ready[0];
    assign div_ready_o = ready[1];
    assign csr_ready_o = ready[2];
    assign alu_ready_o = ready[3];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rf_we_q  <= 1'b0;
            csr_we_q <= 1'b0;
        end else begin
            rf_we_q  <= sel_wr.we;
            csr_we_q <= csr_wr_i.we;
        end
    end

    always_ff @(posedge clk) begin
        rf_addr_q  <= sel_wr.addr;
        rf_data_q  <= sel_wr.data;
        rf_id_q    <= sel_wr.id;
        csr_addr_q <= csr_wr_i.addr;
        csr_data_q <= csr_wr_i.data;
    end

    // every register write also reports its commit, x0 included
    assign rf_wr_o  = '{we: rf_we_q, addr: rf_addr_q, data: rf_data_q, id: rf_id_q};
    assign commit_o = '{valid: rf_we_q, id: rf_id_q};
    assign csr_wr_o = '{we: csr_we_q, addr: csr_addr_q, data: csr_data_q};

    // lsu never waits, whatever is parked
    a_lsu_next_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_wr_i.we |=> commit_o.valid && commit_o.id == $past(lsu_wr_i.id));

    // the port is never shared between an lsu write and a pop
    a_one_source: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({lsu_wr_i.we, fifo_pop}));

    // parked writes are not left waiting on an idle port
    a_drain: assert property (@(posedge clk) disable iff (!rst_n)
        !lsu_wr_i.we && !(&fifo_empty) |-> grant != NONE);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the writeback testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module wb_tb -f build.f

if ./obj_dir/Vwb_tb 2>&1 | tee /dev/stderr | grep -x "Simulation passed" > /dev/null; then
    echo "run_sim: PASS"
    exit 0
else
    echo "run_sim: FAIL"
    exit 1
fi

// ==== sim/wb_tb.sv ====
// writeback testbench: producer traffic, commit tracking and register file checks
`timescale 1ns/1ns

module wb_tb;
    import core_cfg_pkg::*;
    import wb_pkg::*;

    localparam int FIFO_DEPTH    = 2;
    localparam int RAND_CYCLES   = 300;
    localparam int IDLE_TIMEOUT  = 80;
    localparam int READY_TIMEOUT = 40;

    logic      clk;
    logic      rst_n;
    reg_wr_t   lsu_wr;
    reg_wr_t   mul_wr;
    reg_wr_t   div_wr;
    reg_wr_t   csr_reg_wr;
    reg_wr_t   alu_wr;
    csr_wr_t   csr_wr;
    reg_addr_t rs_addr;
    logic      mul_ready;
    logic      div_ready;
    logic      csr_ready;
    logic      alu_ready;
    commit_t   commit;
    csr_wr_t   csr_out;
    reg_data_t rs_data;

    // index 0 lsu, 1 mul, 2 div, 3 csr, 4 alu; also the commit id of that source
    reg_wr_t     req [5];
    csr_wr_t     csr_req;
    reg_wr_t     exp_q [5][$];
    int          due_q [5][$];
    reg_data_t   model_rf [32];
    logic [31:0] rng;
    int          cycle;
    logic        strict_mode;
    csr_wr_t     csr_sampled;
    reg_addr_t   probe_addr;
    reg_addr_t   cmp_addr;
    logic        cmp_active;
    logic        rb_pending;
    reg_addr_t   rb_addr;
    reg_data_t   rb_data;

    // read port shared by the commit checker and the register sweeps
    assign rs_addr = cmp_active ? cmp_addr : probe_addr;

    wb_top #(.FIFO_DEPTH(FIFO_DEPTH)) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .lsu_wr_i     (lsu_wr),
        .mul_wr_i     (mul_wr),
        .div_wr_i     (div_wr),
        .csr_reg_wr_i (csr_reg_wr),
        .alu_wr_i     (alu_wr),
        .csr_wr_i     (csr_wr),
        .rs_addr_i    (rs_addr),
        .mul_ready_o  (mul_ready),
        .div_ready_o  (div_ready),
        .csr_ready_o  (csr_ready),
        .alu_ready_o  (alu_ready),
        .commit_o     (commit),
        .csr_wr_o     (csr_out),
        .rs_data_o    (rs_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle       <= cycle + 1;
        csr_sampled <= csr_wr;
    end

    task automatic stop_sim();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic fail_with(input string why);
        $display("ERROR: %s", why);
        stop_sim();
    endtask

    task automatic check_commit(input commit_t got, input commit_t exp, input string name);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            stop_sim();
        end
    endtask

    task automatic check_reg(input reg_data_t got, input reg_data_t exp, input string name);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            stop_sim();
        end
    endtask

    task automatic check_csr(input csr_wr_t got, input csr_wr_t exp, input string name);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            stop_sim();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            stop_sim();
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // six private destination registers per source, x1 to x30
    function automatic reg_wr_t make_write(input int src, input logic [31:0] r);
        reg_wr_t w;
        w.we   = 1'b1;
        w.addr = reg_addr_t'(src * 6 + 1 + int'(r[7:5]) % 6);
        w.data = r;
        w.id   = commit_id_t'(src);
        return w;
    endfunction

    // reference read, x0 always zero
    function automatic reg_data_t expected_read(input reg_addr_t a);
        if (a == '0) begin
            return '0;
        end
        return model_rf[a];
    endfunction

    function automatic logic src_ready(input int s);
        case (s)
            1:       return mul_ready;
            2:       return div_ready;
            3:       return csr_ready;
            4:       return alu_ready;
            default: return 1'b1;
        endcase
    endfunction

    function automatic logic busy();
        if (rb_pending) begin
            return 1'b1;
        end
        for (int s = 0; s < 5; s++) begin
            if (req[s].we || exp_q[s].size() != 0) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // drive on the falling edge, ready is stable until the next rising edge
    task automatic cycle_step();
        @(negedge clk);
        lsu_wr     = req[0];
        mul_wr     = req[1];
        div_wr     = req[2];
        csr_reg_wr = req[3];
        alu_wr     = req[4];
        csr_wr     = csr_req;
        #1;
        for (int s = 0; s < 5; s++) begin
            if (req[s].we && src_ready(s)) begin
                exp_q[s].push_back(req[s]);
                due_q[s].push_back((s == 0 || strict_mode) ? cycle + 1 : -1);
                req[s].we = 1'b0;
            end
        end
        csr_req.we = 1'b0;
    endtask

    task automatic wait_idle(input string what);
        int n;
        n = 0;
        while (busy()) begin
            if (n >= IDLE_TIMEOUT) begin
                fail_with({"timeout waiting for ", what});
            end
            cycle_step();
            n++;
        end
    endtask

    task automatic sweep_regs();
        for (int a = 0; a < 32; a++) begin
            probe_addr = reg_addr_t'(a);
            #1;
            check_reg(rs_data, expected_read(probe_addr), "rs_data_o");
        end
    endtask

    // each commit pops the head of its source queue
    // the register file takes the write one edge later, so it is read back then
    always @(negedge clk) begin : compare_commits
        reg_wr_t   head;
        commit_t   exp_c;
        int        src;
        int        due;
        logic      rb_now;
        reg_addr_t rb_now_addr;
        reg_data_t rb_now_data;
        rb_now      = rb_pending;
        rb_now_addr = rb_addr;
        rb_now_data = rb_data;
        rb_pending  = 1'b0;
        if (rst_n) begin
            check_csr(csr_out, csr_sampled, "csr_wr_o");
            // a write with known timing must be the one committing now
            exp_c = '0;
            for (int s = 0; s < 5; s++) begin
                if (due_q[s].size() != 0 && due_q[s][0] == cycle) begin
                    exp_c.valid = 1'b1;
                    exp_c.id    = commit_id_t'(s);
                end
            end
            if (exp_c.valid) begin
                check_commit(commit, exp_c, "commit_o");
            end
        end
        if (rst_n && commit.valid) begin
            src = int'(commit.id);
            if (src > 4 || exp_q[src].size() == 0) begin
                fail_with($sformatf("commit with id %0d matches no accepted write", src));
            end
            head = exp_q[src].pop_front();
            due  = due_q[src].pop_front();
            if (due >= 0 && due != cycle) begin
                fail_with($sformatf("source %0d committed at cycle %0d, not at cycle %0d",
                                    src, cycle, due));
            end
            if (head.addr != '0) begin
                model_rf[head.addr] = head.data;
            end
            rb_pending = 1'b1;
            rb_addr    = head.addr;
            rb_data    = expected_read(head.addr);
        end
        if (rb_now) begin
            cmp_addr   = rb_now_addr;
            cmp_active = 1'b1;
            #1;
            check_reg(rs_data, rb_now_data, "rs_data_o");
            cmp_active = 1'b0;
        end
    end

    initial begin
        rst_n       = 1'b0;
        lsu_wr      = '0;
        mul_wr      = '0;
        div_wr      = '0;
        csr_reg_wr  = '0;
        alu_wr      = '0;
        csr_wr      = '0;
        csr_req     = '0;
        probe_addr  = '0;
        cmp_addr    = '0;
        cmp_active  = 1'b0;
        rb_pending  = 1'b0;
        rb_addr     = '0;
        rb_data     = '0;
        strict_mode = 1'b0;
        cycle       = 0;
        rng         = 32'd51;
        for (int s = 0; s < 5; s++) begin
            req[s] = '0;
        end
        for (int a = 0; a < 32; a++) begin
            model_rf[a] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // idle state after reset
        cycle_step();
        check_flag(commit.valid, 1'b0, "commit_o.valid");
        check_flag(csr_out.we, 1'b0, "csr_wr_o.we");
        check_flag(mul_ready, 1'b1, "mul_ready_o");
        check_flag(div_ready, 1'b1, "div_ready_o");
        check_flag(csr_ready, 1'b1, "csr_ready_o");
        check_flag(alu_ready, 1'b1, "alu_ready_o");
        sweep_regs();

        // lone writes commit one cycle after acceptance, the last one aims at x0
        for (int s = 0; s < 6; s++) begin
            rng = xorshift(rng);
            req[s % 5] = make_write(s % 5, rng);
            if (s == 5) begin
                req[0].addr = '0;
            end
            strict_mode = 1'b1;
            cycle_step();
            strict_mode = 1'b0;
            wait_idle("a lone write to commit");
        end

        // lsu keeps its timing while other writes sit parked
        for (int i = 0; i < 4; i++) begin
            for (int s = 0; s < 5; s++) begin
                rng = xorshift(rng);
                if (s == 0 || (i == 0 && s != 3)) begin
                    req[s] = make_write(s, rng);
                end
            end
            cycle_step();
        end
        wait_idle("parked writes behind the lsu");

        // mul FIFO fills behind a busy lsu, its write has to be held
        for (int i = 0; i < FIFO_DEPTH + 3; i++) begin
            rng = xorshift(rng);
            req[0] = make_write(0, rng);
            if (!req[1].we) begin
                req[1] = make_write(1, xorshift(rng));
            end
            cycle_step();
        end
        check_flag(mul_ready, 1'b0, "mul_ready_o");
        if (!req[1].we) begin
            fail_with("mul write was taken while its FIFO was full");
        end
        for (int n = 0; !mul_ready; n++) begin
            if (n >= READY_TIMEOUT) begin
                fail_with("mul_ready_o did not recover after the lsu went idle");
            end
            cycle_step();
        end
        wait_idle("the held mul write");

        // random traffic, lsu on a quarter of the cycles, others held until taken
        for (int c = 0; c < RAND_CYCLES; c++) begin
            for (int s = 0; s < 5; s++) begin
                rng = xorshift(rng);
                if (s == 0 ? (rng[31:30] == 2'b00) : (!req[s].we && rng[31])) begin
                    req[s] = make_write(s, rng);
                end
            end
            rng     = xorshift(rng);
            csr_req = '{we: rng[0], addr: rng[12:1], data: rng ^ 32'h5a5a_a5a5};
            cycle_step();
        end
        wait_idle("random traffic to drain");
        sweep_regs();

        $display("Simulation passed");
        $finish;
    end

endmodule
